// File: common/backend_pkg.sv
/*
 * Shared types of the memory and writeback back end: operation enums,
 * the stage records, the data-memory request and the commit record.
 */
`default_nettype none

package backend_pkg;

        localparam int REG_ADDR_W = 5;             // Width of an rd or rs field.

        typedef enum logic [3:0] {
                MEM_NONE,
                MEM_LB,
                MEM_LH,
                MEM_LW,
                MEM_LBU,
                MEM_LHU,
                MEM_SB,
                MEM_SH,
                MEM_SW
        } mem_op_e;

        typedef enum logic [1:0] {
                WB_ALU,
                WB_CSR,
                WB_LOAD,
                WB_LINK                            // Return address, pc plus 4.
        } wb_src_e;

        typedef struct packed {
                logic                  valid;
                logic [31:0]           pc;
                logic [31:0]           inst;
                logic [31:0]           alu_out;    // Also the data-memory address.
                logic [31:0]           csr_out;
                logic [31:0]           store_data;
                logic [REG_ADDR_W-1:0] rd;
                logic                  rd_we;
                wb_src_e               wb_src;
                mem_op_e               mem_op;
                logic                  halt;
        } ex_mem_t;

        typedef struct packed {
                logic                  valid;
                logic [31:0]           pc;
                logic [31:0]           inst;
                logic [31:0]           alu_out;
                logic [31:0]           csr_out;
                logic [31:0]           load_data;  // Already aligned and extended.
                logic [REG_ADDR_W-1:0] rd;
                logic                  rd_we;
                wb_src_e               wb_src;
                logic                  halt;
        } mem_wb_t;

        typedef struct packed {
                logic        valid;
                logic        write;
                logic [31:0] addr;                 // Word aligned.
                logic [31:0] wdata;
                logic [3:0]  wstrb;
        } dmem_req_t;

        typedef struct packed {
                logic                  valid;
                logic [31:0]           pc;
                logic [31:0]           inst;
                logic [REG_ADDR_W-1:0] rd;
                logic                  rd_we;
                logic [31:0]           wdata;
        } commit_t;

endpackage

`default_nettype wire

// File: verilog/pipeline_control.sv
/*
 * Back-end control: memory stall, MEM flush, WB hold, halted flag
 * and writeback enable.
 */
`timescale 1ns/1ps
`default_nettype none

module pipeline_control import backend_pkg::*; (
        input  logic    clk,
        input  logic    reset,
        input  logic    ex_valid,
        input  mem_op_e ex_mem_op,
        input  logic    flush,
        input  logic    dmem_ready,
        input  logic    wb_valid,
        input  logic    wb_halt,
        output logic    mem_go,
        output logic    mem_stall,
        output logic    flush_me,
        output logic    stall_wb,
        output logic    wb_enable,
        output logic    halted
);

        logic mem_wait;

        // A request goes out only for a live memory instruction.
        assign mem_go = ex_valid && (ex_mem_op != MEM_NONE) && !flush && !halted;

        assign mem_wait  = mem_go && !dmem_ready;  // Access not finished this cycle.
        assign mem_stall = mem_wait || halted;

        // While waiting on memory, WB receives a bubble instead of a duplicate.
        assign flush_me  = !halted && (flush || mem_wait);
        assign stall_wb  = halted;
        assign wb_enable = !halted;

        always_ff @(posedge clk) begin
                if (reset) begin
                        halted <= 1'b0;
                end else if (wb_valid && wb_halt) begin
                        halted <= 1'b1;            // Sticky until reset.
                end
        end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
/*
 * MEM stage datapath: data-memory request with byte strobes,
 * load alignment and extension, and packing of the MEM/WB record.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import backend_pkg::*; (
        input  ex_mem_t     ex_in,
        input  logic        mem_go,
        input  logic [31:0] dmem_rdata,
        output dmem_req_t   dmem_req,
        output mem_wb_t     mem_out
);

        logic [1:0]  offset;
        logic [7:0]  byte_sel;
        logic [15:0] half_sel;
        logic [31:0] load_data;

        assign offset   = ex_in.alu_out[1:0];
        assign byte_sel = dmem_rdata[offset*8 +: 8];
        assign half_sel = offset[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

        always_comb begin
                dmem_req.valid = mem_go;           // Control has already checked the op.
                dmem_req.addr  = {ex_in.alu_out[31:2], 2'b00};
                dmem_req.write = 1'b0;
                dmem_req.wdata = ex_in.store_data;
                dmem_req.wstrb = 4'b0000;
                case (ex_in.mem_op)
                        MEM_SB: begin
                                dmem_req.write = 1'b1;
                                dmem_req.wdata = {4{ex_in.store_data[7:0]}};
                                dmem_req.wstrb = 4'b0001 << offset;
                        end
                        MEM_SH: begin
                                dmem_req.write = 1'b1;
                                dmem_req.wdata = {2{ex_in.store_data[15:0]}};
                                dmem_req.wstrb = offset[1] ? 4'b1100 : 4'b0011;
                        end
                        MEM_SW: begin
                                dmem_req.write = 1'b1;
                                dmem_req.wstrb = 4'b1111;
                        end
                        default: ;                 // Loads read the whole word.
                endcase
        end

        always_comb begin
                case (ex_in.mem_op)
                        MEM_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
                        MEM_LBU: load_data = {24'b0, byte_sel};
                        MEM_LH:  load_data = {{16{half_sel[15]}}, half_sel};
                        MEM_LHU: load_data = {16'b0, half_sel};
                        MEM_LW:  load_data = dmem_rdata;
                        default: load_data = 32'b0;
                endcase
        end

        always_comb begin
                mem_out.valid     = ex_in.valid;   // Bubbles are made in the segment register.
                mem_out.pc        = ex_in.pc;
                mem_out.inst      = ex_in.inst;
                mem_out.alu_out   = ex_in.alu_out;
                mem_out.csr_out   = ex_in.csr_out;
                mem_out.load_data = load_data;
                mem_out.rd        = ex_in.rd;
                mem_out.rd_we     = ex_in.rd_we;
                mem_out.wb_src    = ex_in.wb_src;
                mem_out.halt      = ex_in.halt;
        end

endmodule

`default_nettype wire

// File: verilog/mem_wb_seg_reg.sv
/*
 * MEM/WB segment register; holds on stall, clears to a bubble on flush.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_seg_reg import backend_pkg::*; (
        input  logic    clk,
        input  logic    reset,
        input  logic    flush_me,
        input  logic    stall_wb,
        input  mem_wb_t mem_in,
        output mem_wb_t wb_out
);

        // A stall wins over a flush so that a frozen WB keeps its instruction.
        always_ff @(posedge clk) begin
                if (reset || (flush_me && !stall_wb)) begin
                        wb_out <= '0;
                end else if (!stall_wb) begin
                        wb_out <= mem_in;
                end
        end

endmodule

`default_nettype wire

// File: writeback/wb_select.sv
/*
 * Writeback select: result mux, register-file write and commit record.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_select import backend_pkg::*; (
        input  mem_wb_t               wb_in,
        input  logic                  wb_enable,
        output logic                  rf_we,
        output logic [REG_ADDR_W-1:0] rf_waddr,
        output logic [31:0]           rf_wdata,
        output commit_t               commit
);

        always_comb begin
                case (wb_in.wb_src)
                        WB_ALU:  rf_wdata = wb_in.alu_out;
                        WB_CSR:  rf_wdata = wb_in.csr_out;
                        WB_LOAD: rf_wdata = wb_in.load_data;
                        WB_LINK: rf_wdata = wb_in.pc + 32'd4;
                        default: rf_wdata = wb_in.alu_out;
                endcase
        end

        // x0 is never written, so the write enable also drops for rd of zero.
        assign rf_we    = wb_enable && wb_in.valid && wb_in.rd_we && (wb_in.rd != '0);
        assign rf_waddr = wb_in.rd;

        always_comb begin
                commit.valid = wb_enable && wb_in.valid;
                commit.pc    = wb_in.pc;
                commit.inst  = wb_in.inst;
                commit.rd    = wb_in.rd;
                commit.rd_we = rf_we;              // Only writes that really happen.
                commit.wdata = rf_wdata;
        end

endmodule

`default_nettype wire

// File: writeback/reg_file.sv
/*
 * Integer register file with hardwired x0 and two bypassed read ports.
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file import backend_pkg::*; #(
        parameter int REG_COUNT = 32
) (
        input  logic                  clk,
        input  logic                  reset,
        input  logic                  we,
        input  logic [REG_ADDR_W-1:0] waddr,
        input  logic [31:0]           wdata,
        input  logic [REG_ADDR_W-1:0] rs1_addr,
        input  logic [REG_ADDR_W-1:0] rs2_addr,
        output logic [31:0]           rs1_data,
        output logic [31:0]           rs2_data
);

        logic [31:0] regs [REG_COUNT];

        // Registers beyond REG_COUNT (RV32E) read as zero, as does x0.
        function automatic logic [31:0] read_port(input logic [REG_ADDR_W-1:0] addr);
                if (addr == '0 || int'(addr) >= REG_COUNT) begin
                        return 32'b0;
                end else if (we && addr == waddr) begin
                        return wdata;              // WB-to-decode bypass.
                end
                return regs[addr];
        endfunction

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < REG_COUNT; i++) begin
                                regs[i] <= 32'b0;
                        end
                end else if (we && waddr != '0 && int'(waddr) < REG_COUNT) begin
                        regs[waddr] <= wdata;
                end
        end

        // The read ports follow the stored registers and the write port.
        always_comb begin
                rs1_data = read_port(rs1_addr);
                rs2_data = read_port(rs2_addr);
        end

endmodule

`default_nettype wire

// File: verilog/backend_top.sv
/*
 * Back-end top level: control, MEM stage, MEM/WB register,
 * writeback select and register file.
 */
`timescale 1ns/1ps
`default_nettype none

module backend_top import backend_pkg::*; #(
        parameter int REG_COUNT = 32
) (
        input  logic                  clk,
        input  logic                  reset,
        input  ex_mem_t               ex_in,
        input  logic                  flush,
        output logic                  mem_stall,
        output dmem_req_t             dmem_req,
        input  logic [31:0]           dmem_rdata,
        input  logic                  dmem_ready,
        input  logic [REG_ADDR_W-1:0] rs1_addr,
        input  logic [REG_ADDR_W-1:0] rs2_addr,
        output logic [31:0]           rs1_data,
        output logic [31:0]           rs2_data,
        output commit_t               commit,
        output logic                  halted
);

        logic                  mem_go;
        logic                  flush_me;
        logic                  stall_wb;
        logic                  wb_enable;
        mem_wb_t               mem_out;
        mem_wb_t               wb_out;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        logic [31:0]           rf_wdata;

        pipeline_control u_control (
                .clk        (clk),
                .reset      (reset),
                .ex_valid   (ex_in.valid),
                .ex_mem_op  (ex_in.mem_op),
                .flush      (flush),
                .dmem_ready (dmem_ready),
                .wb_valid   (wb_out.valid),
                .wb_halt    (wb_out.halt),
                .mem_go     (mem_go),
                .mem_stall  (mem_stall),
                .flush_me   (flush_me),
                .stall_wb   (stall_wb),
                .wb_enable  (wb_enable),
                .halted     (halted)
        );

        mem_stage u_mem (
                .ex_in      (ex_in),
                .mem_go     (mem_go),
                .dmem_rdata (dmem_rdata),
                .dmem_req   (dmem_req),
                .mem_out    (mem_out)
        );

        mem_wb_seg_reg u_mem_wb (
                .clk      (clk),
                .reset    (reset),
                .flush_me (flush_me),
                .stall_wb (stall_wb),
                .mem_in   (mem_out),
                .wb_out   (wb_out)
        );

        wb_select u_wb (
                .wb_in     (wb_out),
                .wb_enable (wb_enable),
                .rf_we     (rf_we),
                .rf_waddr  (rf_waddr),
                .rf_wdata  (rf_wdata),
                .commit    (commit)
        );

        reg_file #(
                .REG_COUNT (REG_COUNT)
        ) u_regs (
                .clk      (clk),
                .reset    (reset),
                .we       (rf_we),
                .waddr    (rf_waddr),
                .wdata    (rf_wdata),
                .rs1_addr (rs1_addr),
                .rs2_addr (rs2_addr),
                .rs1_data (rs1_data),
                .rs2_data (rs2_data)
        );

endmodule

`default_nettype wire

// File: testbench/backend_assertions.sv
/*
 * Protocol assertions on the back-end control, bound to pipeline_control.
 */
`timescale 1ns/1ps
`default_nettype none

module backend_assertions (
        input logic clk,
        input logic reset,
        input logic mem_go,
        input logic mem_stall,
        input logic flush_me,
        input logic stall_wb,
        input logic wb_enable,
        input logic wb_valid,
        input logic halted
);

        int fail_count = 0;

        // A flushed or waiting MEM instruction leaves a bubble in WB.
        a_flush_bubble: assert property (@(posedge clk) disable iff (reset)
                (flush_me && !stall_wb) |=> !wb_valid)
                else begin
                        $error("WB holds a valid instruction after a MEM flush");
                        fail_count++;
                end

        a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
                halted |=> halted)
                else begin
                        $error("halted dropped without a reset");
                        fail_count++;
                end

        // Out of reset the back end runs, and only a request can stall it.
        a_reset_state: assert property (@(posedge clk)
                reset |=> !halted && !stall_wb && wb_enable && (mem_go || !mem_stall))
                else begin
                        $error("control outputs not idle after reset");
                        fail_count++;
                end

endmodule

`default_nettype wire

// File: testbench/backend_tb.sv
/*
 * Testbench for the back end: clock, reset, LFSR stimulus, data-memory model,
 * reference model, checking assertions and watchdog.
 */
`timescale 1ns/1ps
`default_nettype none

module backend_tb import backend_pkg::*; ();

        localparam int N_INSTR    = 2000;
        localparam int MAX_DELAY  = 3;
        localparam int TIMEOUT_NS = (N_INSTR * (MAX_DELAY + 2) + 200) * 10;
        localparam logic [31:0] HALT_PC = 32'h0000_fff0;

        logic                  clk;
        logic                  reset;
        ex_mem_t               ex_in;
        logic                  flush;
        logic                  mem_stall;
        dmem_req_t             dmem_req;
        logic [31:0]           dmem_rdata;
        logic                  dmem_ready;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic [31:0]           rs1_data;
        logic [31:0]           rs2_data;
        commit_t               commit;
        logic                  halted;

        logic [31:0] mem [256];                    // Memory model, written by DUT requests.
        logic [31:0] ref_mem [256];                // Same contents as seen by the model.
        logic [31:0] exp_regs [32];
        commit_t     exp_q [$];
        commit_t     exp_head;
        dmem_req_t   exp_req;
        logic [31:0] exp_rs1;
        logic [31:0] exp_rs2;
        logic        exp_stall;
        logic        exp_halted;
        logic        wb_live;                      // Head of the queue is in WB this cycle.
        logic        pending_accept;
        logic        req_ok;
        logic [15:0] lfsr;
        int          mismatches;
        int          failures;

        backend_top #(.REG_COUNT(32)) UUT (.*);

        bind pipeline_control backend_assertions ctrl_checks (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        assign dmem_rdata = mem[dmem_req.addr[9:2]];

        always @(posedge clk) begin
                if (dmem_req.valid && dmem_req.write && dmem_ready) begin
                        for (int b = 0; b < 4; b++) begin
                                if (dmem_req.wstrb[b]) begin
                                        mem[dmem_req.addr[9:2]][b*8 +: 8] <= dmem_req.wdata[b*8 +: 8];
                                end
                        end
                end
        end

        // Taps 16, 14, 13, 11 give a maximal-length sequence.
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        function automatic logic [31:0] take_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_next(lfsr);
                        v = {v[30:0], lfsr[0]};
                end
                return v;
        endfunction

        function automatic logic [31:0] fill_word(input int i);
                return (32'h9e37_79b9 * 32'(i + 1)) ^ 32'(i << 12);
        endfunction

        function automatic int access_bytes(input mem_op_e op);
                case (op)
                        MEM_LB, MEM_LBU, MEM_SB: return 1;
                        MEM_LH, MEM_LHU, MEM_SH: return 2;
                        default:                 return 4;
                endcase
        endfunction

        function automatic logic [31:0] load_value(input mem_op_e op, input logic [31:0] addr);
                logic [31:0] word;
                word = ref_mem[addr[9:2]] >> (8 * addr[1:0]);  // Addressed lane moved to bit 0.
                case (op)
                        MEM_LB:  return {{24{word[7]}}, word[7:0]};
                        MEM_LBU: return {24'b0, word[7:0]};
                        MEM_LH:  return {{16{word[15]}}, word[15:0]};
                        MEM_LHU: return {16'b0, word[15:0]};
                        default: return ref_mem[addr[9:2]];
                endcase
        endfunction

        // Only the lanes enabled by the strobes carry meaningful write data.
        function automatic logic req_matches(input dmem_req_t got, input dmem_req_t want);
                logic [31:0] mask;
                if (got.valid != want.valid) begin
                        return 1'b0;
                end else if (!want.valid) begin
                        return 1'b1;
                end
                for (int b = 0; b < 4; b++) begin
                        mask[b*8 +: 8] = {8{want.wstrb[b]}};
                end
                return got.write == want.write && got.addr == want.addr
                        && got.wstrb == want.wstrb && (got.wdata & mask) == want.wdata;
        endfunction

        function automatic logic [31:0] read_expect(input logic [REG_ADDR_W-1:0] a);
                if (a == '0) begin
                        return 32'b0;
                end else if (wb_live && exp_head.rd_we && exp_head.rd == a) begin
                        return exp_head.wdata;             // Value being written this cycle.
                end
                return exp_regs[a];
        endfunction

        task automatic next_cycle();
                @(negedge clk);
                if (wb_live && exp_q.size() > 0) begin
                        if (exp_head.rd_we) begin
                                exp_regs[exp_head.rd] = exp_head.wdata;
                        end
                        if (exp_head.pc == HALT_PC) begin
                                exp_halted = 1'b1;
                        end
                        void'(exp_q.pop_front());
                end
                wb_live = pending_accept;
                pending_accept = 1'b0;
                exp_head = '0;
                if (exp_q.size() > 0) begin
                        exp_head = exp_q[0];
                end
                rs1_addr = wb_live ? exp_head.rd : REG_ADDR_W'(take_bits(5));
                rs2_addr = REG_ADDR_W'(take_bits(5));
                exp_rs1 = read_expect(rs1_addr);
                exp_rs2 = read_expect(rs2_addr);
        endtask

        task automatic run_instruction(input int idx, input logic halt);
                ex_mem_t ins;
                commit_t want;
                logic    fl;
                logic    is_mem;
                logic    is_store;
                int      delay;
                int      lane;
                ins = '0;
                ins.valid = 1'b1;
                ins.halt = halt;
                ins.pc = halt ? HALT_PC : 32'h0000_1000 + 32'(idx) * 4;
                ins.inst = take_bits(32);
                ins.csr_out = take_bits(32);
                ins.store_data = take_bits(32);
                ins.rd = REG_ADDR_W'(take_bits(5));
                ins.mem_op = halt ? MEM_NONE : mem_op_e'(4'(take_bits(4) % 9));
                is_mem = ins.mem_op != MEM_NONE;
                is_store = ins.mem_op inside {MEM_SB, MEM_SH, MEM_SW};
                if (is_mem) begin
                        ins.alu_out = take_bits(6);        // 16 words, so loads hit earlier stores.
                        if (access_bytes(ins.mem_op) == 2) begin
                                ins.alu_out[0] = 1'b0;
                        end else if (access_bytes(ins.mem_op) == 4) begin
                                ins.alu_out[1:0] = 2'b00;
                        end
                end else begin
                        ins.alu_out = take_bits(32);
                end
                if (is_mem && !is_store) begin
                        ins.wb_src = WB_LOAD;
                end else begin
                        case (take_bits(2))
                                32'd0, 32'd1: ins.wb_src = WB_ALU;
                                32'd2:        ins.wb_src = WB_CSR;
                                default:      ins.wb_src = WB_LINK;
                        endcase
                end
                ins.rd_we = !is_store && (take_bits(3) != 0);
                fl = !halt && (take_bits(4) == 0);
                delay = (is_mem && !fl) ? int'(take_bits(2)) : 0;

                exp_req = '0;
                if (is_mem && !fl) begin
                        exp_req.valid = 1'b1;
                        exp_req.write = is_store;
                        exp_req.addr = {ins.alu_out[31:2], 2'b00};
                        for (int b = 0; b < access_bytes(ins.mem_op); b++) begin
                                lane = int'(ins.alu_out[1:0]) + b;
                                if (is_store) begin
                                        exp_req.wstrb[lane] = 1'b1;
                                        exp_req.wdata[lane*8 +: 8] = ins.store_data[b*8 +: 8];
                                        ref_mem[ins.alu_out[9:2]][lane*8 +: 8] = ins.store_data[b*8 +: 8];
                                end
                        end
                end
                if (!fl) begin
                        want = '0;
                        want.valid = 1'b1;
                        want.pc = ins.pc;
                        want.inst = ins.inst;
                        want.rd = ins.rd;
                        want.rd_we = ins.rd_we && ins.rd != '0;
                        case (ins.wb_src)
                                WB_ALU:  want.wdata = ins.alu_out;
                                WB_CSR:  want.wdata = ins.csr_out;
                                WB_LOAD: want.wdata = load_value(ins.mem_op, ins.alu_out);
                                default: want.wdata = ins.pc + 32'd4;
                        endcase
                        exp_q.push_back(want);
                end

                ex_in = ins;
                flush = fl;
                for (int d = delay; d >= 0; d--) begin
                        dmem_ready = (d == 0);
                        exp_stall = (d != 0);
                        pending_accept = (d == 0) && !fl;
                        next_cycle();
                end
        endtask

        assign req_ok = req_matches(dmem_req, exp_req);

        a_commit_valid: assert property (@(posedge clk) disable iff (reset)
                commit.valid == wb_live)
                else begin
                        $display("MISMATCH time=%0t commit.valid expected=%0b got=%0b",
                                 $time, $sampled(wb_live), $sampled(commit.valid));
                        mismatches++;
                end

        a_commit: assert property (@(posedge clk) disable iff (reset)
                wb_live |-> commit == exp_head)
                else begin
                        $display("MISMATCH time=%0t commit expected=%h got=%h",
                                 $time, $sampled(exp_head), $sampled(commit));
                        mismatches++;
                end

        a_rs1: assert property (@(posedge clk) disable iff (reset) rs1_data == exp_rs1)
                else begin
                        $display("MISMATCH time=%0t rs1_data expected=%h got=%h",
                                 $time, $sampled(exp_rs1), $sampled(rs1_data));
                        mismatches++;
                end

        a_rs2: assert property (@(posedge clk) disable iff (reset) rs2_data == exp_rs2)
                else begin
                        $display("MISMATCH time=%0t rs2_data expected=%h got=%h",
                                 $time, $sampled(exp_rs2), $sampled(rs2_data));
                        mismatches++;
                end

        a_request: assert property (@(posedge clk) disable iff (reset) req_ok)
                else begin
                        $display("MISMATCH time=%0t dmem_req expected=%h got=%h",
                                 $time, $sampled(exp_req), $sampled(dmem_req));
                        mismatches++;
                end

        a_stall: assert property (@(posedge clk) disable iff (reset)
                mem_stall == (exp_stall || exp_halted))
                else begin
                        $display("MISMATCH time=%0t mem_stall expected=%0b got=%0b",
                                 $time, $sampled(exp_stall || exp_halted), $sampled(mem_stall));
                        mismatches++;
                end

        a_halted: assert property (@(posedge clk) disable iff (reset) halted == exp_halted)
                else begin
                        $display("MISMATCH time=%0t halted expected=%0b got=%0b",
                                 $time, $sampled(exp_halted), $sampled(halted));
                        mismatches++;
                end

        initial begin
                lfsr = 16'd98;
                reset = 1'b1;
                ex_in = '0;
                flush = 1'b0;
                dmem_ready = 1'b1;
                rs1_addr = '0;
                rs2_addr = '0;
                exp_req = '0;
                exp_head = '0;
                exp_rs1 = '0;
                exp_rs2 = '0;
                exp_stall = 1'b0;
                exp_halted = 1'b0;
                wb_live = 1'b0;
                pending_accept = 1'b0;
                mismatches = 0;
                failures = 0;
                for (int i = 0; i < 256; i++) begin
                        mem[i] = fill_word(i);
                        ref_mem[i] = fill_word(i);
                end
                for (int i = 0; i < 32; i++) begin
                        exp_regs[i] = 32'b0;
                end
                repeat (10) @(negedge clk);
                reset = 1'b0;

                for (int i = 0; i < N_INSTR; i++) begin
                        run_instruction(i, 1'b0);
                end
                run_instruction(N_INSTR, 1'b1);
                ex_in = '0;
                exp_req = '0;
                exp_stall = 1'b0;
                next_cycle();

                // A store offered while halted must not reach memory or commit.
                ex_in.valid = 1'b1;
                ex_in.pc = 32'h0000_0100;
                ex_in.mem_op = MEM_SW;
                repeat (5) next_cycle();

                if (!halted || exp_q.size() != 0) begin
                        $display("Run ended with halted=%0b and %0d instructions never committed",
                                 halted, exp_q.size());
                        failures++;
                end
                $display("Errors: %0d mismatches, %0d other failures, %0d control assertion failures",
                         mismatches, failures, UUT.u_control.ctrl_checks.fail_count);
                if (mismatches == 0 && failures == 0 && UUT.u_control.ctrl_checks.fail_count == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

        initial begin
                #(TIMEOUT_NS);
                $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
                $display("Test FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// File: sources.f
common/backend_pkg.sv
verilog/pipeline_control.sv
verilog/mem_stage.sv
verilog/mem_wb_seg_reg.sv
writeback/wb_select.sv
writeback/reg_file.sv
verilog/backend_top.sv
testbench/backend_assertions.sv
testbench/backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
